// ==== bench/axi_mem_model.sv ====
// AXI slave memory, at most one write and one read burst outstanding
// 256 beats deep, address bits above bit 10 alias onto the same words
`default_nettype none

module axi_mem_model
(
   input  wire                           sysclk_i,
   input  wire                           reset,
   // random word, one fresh value per clock
   input  wire [31:0]                    rnd_i,
   // write channels
   input  wire axi_burst_pkg::addr_t     awaddr_i,
   input  wire                           awvalid_i,
   output logic                          awready_o,
   input  wire axi_burst_pkg::beat_t     wdata_i,
   input  wire                           wlast_i,
   input  wire                           wvalid_i,
   output logic                          wready_o,
   output logic                          bvalid_o,
   input  wire                           bready_i,
   // read channels
   input  wire axi_burst_pkg::addr_t     araddr_i,
   input  wire axi_burst_pkg::beat_cnt_t arlen_i,
   input  wire                           arvalid_i,
   output logic                          arready_o,
   output axi_burst_pkg::beat_t          rdata_o,
   output logic                          rlast_o,
   output logic                          rvalid_o,
   input  wire                           rready_i,
   // handshake monitors for the checks
   output logic [15:0]                   aw_count_o,
   output logic [15:0]                   ar_count_o,
   output axi_burst_pkg::addr_t          last_awaddr_o,
   output axi_burst_pkg::addr_t          last_araddr_o
);
   timeunit 1ns;
   timeprecision 100ps;

   axi_burst_pkg::beat_t mem [256];
   logic [7:0]           w_idx;
   logic [7:0]           r_idx;
   // beats still to be presented on R
   logic [8:0]           r_left;
   logic                 r_busy;

   ////////////////////////////////////////
   // write side
   ////////////////////////////////////////

   always @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         awready_o     <= 1'b0;
         wready_o      <= 1'b0;
         bvalid_o      <= 1'b0;
         w_idx         <= '0;
         aw_count_o    <= '0;
         last_awaddr_o <= '0;
      end
      else
      begin
         // ready may drop at any time, 50% on AW and 75% on W
         awready_o <= rnd_i[31];
         wready_o  <= rnd_i[30] | rnd_i[29];
         if (awvalid_i && awready_o)
         begin
            w_idx         <= awaddr_i[10:3];
            aw_count_o    <= aw_count_o + 16'd1;
            last_awaddr_o <= awaddr_i;
         end
         if (wvalid_i && wready_o)
         begin
            mem[w_idx] <= wdata_i;
            w_idx      <= w_idx + 8'd1;
            // response right after the last beat
            if (wlast_i)
            begin
               bvalid_o <= 1'b1;
            end
         end
         if (bvalid_o && bready_i)
         begin
            bvalid_o <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // read side
   ////////////////////////////////////////

   always @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         arready_o     <= 1'b0;
         rvalid_o      <= 1'b0;
         rlast_o       <= 1'b0;
         rdata_o       <= '0;
         r_idx         <= '0;
         r_left        <= '0;
         r_busy        <= 1'b0;
         ar_count_o    <= '0;
         last_araddr_o <= '0;
      end
      else
      begin
         arready_o <= rnd_i[28];
         if (arvalid_i && arready_o)
         begin
            r_busy        <= 1'b1;
            r_idx         <= araddr_i[10:3];
            r_left        <= {1'b0, arlen_i} + 9'd1;
            ar_count_o    <= ar_count_o + 16'd1;
            last_araddr_o <= araddr_i;
         end
         // beat taken, burst ends with the rlast beat
         if (rvalid_o && rready_i)
         begin
            rvalid_o <= 1'b0;
            rlast_o  <= 1'b0;
            if (rlast_o)
            begin
               r_busy <= 1'b0;
            end
         end
         // next beat only when the R slot is free, with random gaps
         if ((!rvalid_o || rready_i) && r_busy && (r_left != 9'd0)
             && (rnd_i[27] | rnd_i[26]))
         begin
            rvalid_o <= 1'b1;
            rdata_o  <= mem[r_idx];
            rlast_o  <= (r_left == 9'd1);
            r_idx    <= r_idx + 8'd1;
            r_left   <= r_left - 9'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
// 40 ns clock, reset high from time zero for 16 rising edges
`default_nettype none

module tb_clock_gen
(
   output logic sysclk_o,
   output logic reset_o
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int HALF_PERIOD  = 20;
   localparam int RESET_CYCLES = 16;

   initial
   begin
      sysclk_o = 1'b0;
      forever #HALF_PERIOD sysclk_o = ~sysclk_o;
   end

   // release on a rising edge so the DUT sees a clean first cycle
   initial
   begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge sysclk_o);
      reset_o <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== bench/tb_ddr_page_fifo.sv ====
// page limit 3, base address fixed; every row of the table is a write or a read command
// memory stalls and input FIFO gaps come from one LCG, the same on every run
`default_nettype none

`include "ddr_page_fifo_macros.svh"

module tb_ddr_page_fifo;
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] LCG_SEED = 32'h46c76add;
   localparam int ROWS    = 11;
   localparam int BEATS   = `DPF_BEATS_PER_PAGE;
   localparam int WD_CYCLES = ROWS * BEATS * 50;
   localparam axi_burst_pkg::addr_t BASE = 32'h0004_0200;

   typedef struct packed {
      logic        is_read;
      logic        accept;
      logic [7:0]  slot;
      logic [15:0] exp_written;
      logic [15:0] exp_read;
      logic        exp_full;
   } op_row_t;

   // cmd, accepted, slot, written, read, full
   localparam op_row_t OPS [ROWS] = '{
      '{1'b1, 1'b0, 8'd0, 16'd0, 16'd0, 1'b0},   // read with nothing stored
      '{1'b0, 1'b1, 8'd0, 16'd1, 16'd0, 1'b0},
      '{1'b1, 1'b1, 8'd0, 16'd1, 16'd1, 1'b0},
      '{1'b1, 1'b0, 8'd0, 16'd1, 16'd1, 1'b0},   // no unread page left
      '{1'b0, 1'b1, 8'd1, 16'd2, 16'd1, 1'b0},
      '{1'b0, 1'b1, 8'd2, 16'd3, 16'd1, 1'b1},   // limit reached
      '{1'b0, 1'b0, 8'd0, 16'd3, 16'd1, 1'b1},   // write while full is dropped
      '{1'b1, 1'b1, 8'd1, 16'd3, 16'd2, 1'b1},
      '{1'b1, 1'b1, 8'd2, 16'd0, 16'd0, 1'b0},   // last page out, ledger clears
      '{1'b0, 1'b1, 8'd0, 16'd1, 16'd0, 1'b0},   // back at slot 0
      '{1'b1, 1'b1, 8'd0, 16'd1, 16'd1, 1'b0}
   };

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // word n of the input stream, a scrambled counter
   function automatic axi_burst_pkg::beat_t stream_word(input int unsigned n);
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next(LCG_SEED ^ n);
      lo = lcg_next(hi);
      return {hi, lo};
   endfunction

   logic sysclk;
   logic reset;
   logic write_page = 1'b0;
   logic read_page  = 1'b0;
   axi_burst_pkg::addr_t     base_addr  = BASE;
   page_ctrl_pkg::page_cnt_t page_limit = 16'd3;
   axi_burst_pkg::beat_t     in_data    = '0;
   logic                     in_empty   = 1'b1;
   logic [31:0]              stall_rnd  = LCG_SEED;
   int unsigned              in_ptr     = 0;
   int unsigned              out_cnt    = 0;
   int unsigned              w_beat     = 0;
   logic                     in_rd;
   logic                     out_we;
   logic                     write_done;
   logic                     read_done;
   logic                     mem_full;
   axi_burst_pkg::beat_t     out_data;
   axi_burst_pkg::beat_t     wdata;
   axi_burst_pkg::beat_t     rdata;
   page_ctrl_pkg::page_cnt_t pages_written;
   page_ctrl_pkg::page_cnt_t pages_read;
   axi_burst_pkg::addr_t     awaddr;
   axi_burst_pkg::addr_t     araddr;
   axi_burst_pkg::addr_t     last_awaddr;
   axi_burst_pkg::addr_t     last_araddr;
   axi_burst_pkg::beat_cnt_t awlen;
   axi_burst_pkg::beat_cnt_t arlen;
   logic                     awvalid;
   logic                     awready;
   logic                     wlast;
   logic                     wvalid;
   logic                     wready;
   logic                     bvalid;
   logic                     bready;
   logic                     arvalid;
   logic                     arready;
   logic                     rlast;
   logic                     rvalid;
   logic                     rready;
   logic [15:0]              aw_count;
   logic [15:0]              ar_count;

   tb_clock_gen clock_gen_inst (.sysclk_o(sysclk), .reset_o(reset));

   axi_mem_model mem_model_inst
   (
      .sysclk_i(sysclk), .reset(reset), .rnd_i(stall_rnd),
      .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
      .wdata_i(wdata), .wlast_i(wlast), .wvalid_i(wvalid), .wready_o(wready),
      .bvalid_o(bvalid), .bready_i(bready),
      .araddr_i(araddr), .arlen_i(arlen), .arvalid_i(arvalid), .arready_o(arready),
      .rdata_o(rdata), .rlast_o(rlast), .rvalid_o(rvalid), .rready_i(rready),
      .aw_count_o(aw_count), .ar_count_o(ar_count),
      .last_awaddr_o(last_awaddr), .last_araddr_o(last_araddr)
   );

   ddr_page_fifo ddr_page_fifo_inst
   (
      .sysclk_i(sysclk), .reset(reset),
      .write_page_i(write_page), .read_page_i(read_page),
      .base_addr_i(base_addr), .page_limit_i(page_limit),
      .in_data_i(in_data), .in_empty_i(in_empty), .in_rd_o(in_rd),
      .out_data_o(out_data), .out_we_o(out_we),
      .write_done_o(write_done), .read_done_o(read_done),
      .pages_written_o(pages_written), .pages_read_o(pages_read), .mem_full_o(mem_full),
      .awaddr_o(awaddr), .awlen_o(awlen), .awvalid_o(awvalid), .awready_i(awready),
      .wdata_o(wdata), .wlast_o(wlast), .wvalid_o(wvalid), .wready_i(wready),
      .bvalid_i(bvalid), .bready_o(bready),
      .araddr_o(araddr), .arlen_o(arlen), .arvalid_o(arvalid), .arready_i(arready),
      .rdata_i(rdata), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready)
   );

   task automatic check_val(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
      if (actual !== expected)
      begin
         $display("ERROR %s: expected 0x%h, got 0x%h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   ////////////////////////////////////////
   // stimulus sources
   ////////////////////////////////////////

   always @(posedge sysclk)
   begin
      stall_rnd <= lcg_next(stall_rnd);
   end

   // FWFT input FIFO, it can only turn empty after a pop
   always @(posedge sysclk)
   begin
      if (reset)
      begin
         in_ptr   <= 0;
         in_data  <= stream_word(0);
         in_empty <= 1'b1;
      end
      else
      begin
         if (in_rd)
         begin
            in_ptr  <= in_ptr + 1;
            in_data <= stream_word(in_ptr + 1);
         end
         if (in_empty || in_rd)
         begin
            in_empty <= stall_rnd[25] & stall_rnd[24];
         end
      end
   end

   // reads come back in write order, so output word k is stream word k
   always @(posedge sysclk)
   begin
      if (!reset && out_we)
      begin
         check_val("out_data_o", stream_word(out_cnt), out_data);
         out_cnt <= out_cnt + 1;
      end
   end

   // W beats counted per burst, wlast only on the final one
   always @(posedge sysclk)
   begin
      if (!reset && wvalid && wready)
      begin
         check_val("wlast_o", 64'(w_beat == BEATS - 1), wlast);
         w_beat <= (w_beat == BEATS - 1) ? 0 : w_beat + 1;
      end
   end

   ////////////////////////////////////////
   // table driver
   ////////////////////////////////////////

   task automatic run_row(input int idx);
      op_row_t     row;
      int unsigned out_before;
      logic [15:0] aw_before;
      logic [15:0] ar_before;
      axi_burst_pkg::addr_t slot_addr;
      row        = OPS[idx];
      out_before = out_cnt;
      aw_before  = aw_count;
      ar_before  = ar_count;
      slot_addr  = BASE + axi_burst_pkg::addr_t'(row.slot) * `DPF_PAGE_BYTES;
      @(posedge sysclk);
      if (row.is_read)
         read_page <= 1'b1;
      else
         write_page <= 1'b1;
      @(posedge sysclk);
      read_page  <= 1'b0;
      write_page <= 1'b0;
      if (row.accept)
      begin
         // watchdog covers a done pulse that never comes
         while (!(row.is_read ? read_done : write_done))
            @(posedge sysclk);
         @(posedge sysclk);
      end
      else
      begin
         repeat (20) @(posedge sysclk);
      end
      if (row.is_read)
      begin
         check_val("ar handshakes", 64'(ar_before + row.accept), ar_count);
         check_val("out_we_o beats", row.accept ? BEATS : 0, out_cnt - out_before);
         if (row.accept)
            check_val("araddr_o", slot_addr, last_araddr);
      end
      else
      begin
         check_val("aw handshakes", 64'(aw_before + row.accept), aw_count);
         if (row.accept)
         begin
            check_val("awaddr_o", slot_addr, last_awaddr);
            check_val("awlen_o", BEATS - 1, awlen);
            // response consumed through bready_o
            check_val("bvalid_i", 0, bvalid);
         end
      end
      check_val("pages_written_o", row.exp_written, pages_written);
      check_val("pages_read_o", row.exp_read, pages_read);
      check_val("mem_full_o", row.exp_full, mem_full);
   endtask

   initial
   begin
      wait (reset === 1'b0);
      @(posedge sysclk);
      // quiet outputs right after reset
      check_val("awvalid_o", 0, awvalid);
      check_val("wvalid_o", 0, wvalid);
      check_val("bready_o", 0, bready);
      check_val("arvalid_o", 0, arvalid);
      check_val("rready_o", 0, rready);
      check_val("in_rd_o", 0, in_rd);
      check_val("out_we_o", 0, out_we);
      check_val("write_done_o", 0, write_done);
      check_val("read_done_o", 0, read_done);
      check_val("pages_written_o", 0, pages_written);
      check_val("pages_read_o", 0, pages_read);
      check_val("mem_full_o", 0, mem_full);
      for (int i = 0; i < ROWS; i++)
         run_row(i);
      $display("TEST PASSED");
      $finish;
   end

   initial
   begin
      repeat (16 + WD_CYCLES) @(posedge sysclk);
      $display("watchdog: run timed out after %0d cycles", 16 + WD_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "simulation did not finish in time");
   end

endmodule

`default_nettype wire

// ==== ddr_page_fifo.f ====
+incdir+src
src/axi_burst_pkg.sv
src/page_ctrl_pkg.sv
src/page_write_engine.sv
src/page_ledger.sv
src/page_read_engine.sv
src/ddr_page_fifo.sv
bench/tb_clock_gen.sv
bench/axi_mem_model.sv
bench/tb_ddr_page_fifo.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compiles and runs the ddr_page_fifo testbench with Verilator.
# Exits non-zero when the build, the run or the result check fails.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_ddr_page_fifo

verilator --binary --timing -Wno-fatal \
   -f ddr_page_fifo.f \
   --top-module "$TOP" \
   -Mdir "$OBJ_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
   echo "run.sh: verilator build failed"
   exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "run.sh: simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^TEST PASSED$" "$LOG_FILE"; then
   exit 0
fi
echo "run.sh: pass line not found in $LOG_FILE"
exit 1

// ==== src/axi_burst_pkg.sv ====
// bus side types, widths come from the macro header
`default_nettype none

`include "ddr_page_fifo_macros.svh"

package axi_burst_pkg;

   ////////////////////////////////////////
   // AXI payload types
   ////////////////////////////////////////

   // one data beat on the W or R channel
   typedef logic [`DPF_DATA_W-1:0] beat_t;

   // byte address on the AW and AR channels
   typedef logic [`DPF_ADDR_W-1:0] addr_t;

   // beat index within a burst, also the awlen/arlen encoding
   // (number of beats minus one)
   typedef logic [7:0] beat_cnt_t;

endpackage

`default_nettype wire

// ==== src/ddr_page_fifo.sv ====
// DDR region used as a FIFO of pages, one AXI burst per page
// AXI id, size, burst type and strobes are fixed at the memory side (8-byte INCR)
`default_nettype none

module ddr_page_fifo
(
   input  wire                           sysclk_i,
   input  wire                           reset,
   // commands and configuration
   input  wire                           write_page_i,
   input  wire                           read_page_i,
   input  wire axi_burst_pkg::addr_t     base_addr_i,
   input  wire page_ctrl_pkg::page_cnt_t page_limit_i,
   // input FIFO, first-word-fall-through
   input  wire axi_burst_pkg::beat_t     in_data_i,
   input  wire                           in_empty_i,
   output logic                          in_rd_o,
   // output FIFO
   output axi_burst_pkg::beat_t          out_data_o,
   output logic                          out_we_o,
   // status
   output logic                          write_done_o,
   output logic                          read_done_o,
   output page_ctrl_pkg::page_cnt_t      pages_written_o,
   output page_ctrl_pkg::page_cnt_t      pages_read_o,
   output logic                          mem_full_o,
   // AXI write channels
   output axi_burst_pkg::addr_t          awaddr_o,
   output axi_burst_pkg::beat_cnt_t      awlen_o,
   output logic                          awvalid_o,
   input  wire                           awready_i,
   output axi_burst_pkg::beat_t          wdata_o,
   output logic                          wlast_o,
   output logic                          wvalid_o,
   input  wire                           wready_i,
   input  wire                           bvalid_i,
   output logic                          bready_o,
   // AXI read channels
   output axi_burst_pkg::addr_t          araddr_o,
   output axi_burst_pkg::beat_cnt_t      arlen_o,
   output logic                          arvalid_o,
   input  wire                           arready_i,
   input  wire axi_burst_pkg::beat_t     rdata_i,
   input  wire                           rlast_i,
   input  wire                           rvalid_i,
   output logic                          rready_o
);

   // ledger to engines
   logic                    wr_start;
   logic                    rd_start;
   axi_burst_pkg::addr_t    wr_addr;
   axi_burst_pkg::addr_t    rd_addr;
   // engines back to the ledger, also the external done pulses
   logic                    wr_page_done;
   logic                    rd_page_done;

   assign write_done_o = wr_page_done;
   assign read_done_o  = rd_page_done;

   page_ledger page_ledger_inst
   (
      .sysclk_i        (sysclk_i),
      .reset           (reset),
      .write_page_i    (write_page_i),
      .read_page_i     (read_page_i),
      .base_addr_i     (base_addr_i),
      .page_limit_i    (page_limit_i),
      .wr_page_done_i  (wr_page_done),
      .rd_page_done_i  (rd_page_done),
      .wr_start_o      (wr_start),
      .wr_addr_o       (wr_addr),
      .rd_start_o      (rd_start),
      .rd_addr_o       (rd_addr),
      .pages_written_o (pages_written_o),
      .pages_read_o    (pages_read_o),
      .mem_full_o      (mem_full_o)
   );

   page_write_engine page_write_engine_inst
   (
      .sysclk_i    (sysclk_i),
      .reset       (reset),
      .start_i     (wr_start),
      .page_addr_i (wr_addr),
      .in_data_i   (in_data_i),
      .in_empty_i  (in_empty_i),
      .in_rd_o     (in_rd_o),
      .awaddr_o    (awaddr_o),
      .awlen_o     (awlen_o),
      .awvalid_o   (awvalid_o),
      .awready_i   (awready_i),
      .wdata_o     (wdata_o),
      .wlast_o     (wlast_o),
      .wvalid_o    (wvalid_o),
      .wready_i    (wready_i),
      .bvalid_i    (bvalid_i),
      .bready_o    (bready_o),
      .page_done_o (wr_page_done)
   );

   page_read_engine page_read_engine_inst
   (
      .sysclk_i    (sysclk_i),
      .reset       (reset),
      .start_i     (rd_start),
      .page_addr_i (rd_addr),
      .araddr_o    (araddr_o),
      .arlen_o     (arlen_o),
      .arvalid_o   (arvalid_o),
      .arready_i   (arready_i),
      .rdata_i     (rdata_i),
      .rlast_i     (rlast_i),
      .rvalid_i    (rvalid_i),
      .rready_o    (rready_o),
      .out_data_o  (out_data_o),
      .out_we_o    (out_we_o),
      .page_done_o (rd_page_done)
   );

endmodule

`default_nettype wire

// ==== src/ddr_page_fifo_macros.svh ====
// DPF_BEATS_PER_PAGE must stay at 256 or below since awlen/arlen are 8 bits
// beats are 8 bytes wide, so a page spans beats times 8 bytes in memory
`ifndef DDR_PAGE_FIFO_MACROS_SVH
`define DDR_PAGE_FIFO_MACROS_SVH

////////////////////////////////////////
// burst geometry
////////////////////////////////////////

// beats in one page, one page is one burst
`define DPF_BEATS_PER_PAGE 16
// width of one AXI data beat
`define DPF_DATA_W 64
// AXI byte address width
`define DPF_ADDR_W 32
// byte size of one page slot in memory
`define DPF_PAGE_BYTES (`DPF_BEATS_PER_PAGE * 8)

// width of the written and read page counters
`define DPF_PAGE_CNT_W 16

`endif

// ==== src/page_ctrl_pkg.sv ====
// page control types shared by the ledger and both engines
`default_nettype none

`include "ddr_page_fifo_macros.svh"

package page_ctrl_pkg;

   // number of pages written or read since the last clear
   typedef logic [`DPF_PAGE_CNT_W-1:0] page_cnt_t;

   ////////////////////////////////////////
   // engine state machines
   ////////////////////////////////////////

   // write engine
   // idle, then address phase, data beats, and finally wait for bresp
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_ADDR,
      WR_DATA,
      WR_RESP
   } wr_state_t;

   // read engine
   // no separate response phase, rlast ends the page
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA
   } rd_state_t;

endpackage

`default_nettype wire

// ==== src/page_ledger.sv ====
// page_limit_i must not change while pages are held
// one write and one read may be in flight, further commands are dropped
`default_nettype none

`include "ddr_page_fifo_macros.svh"

module page_ledger
(
   input  wire                          sysclk_i,
   input  wire                          reset,
   // commands, single cycle pulses
   input  wire                          write_page_i,
   input  wire                          read_page_i,
   input  wire axi_burst_pkg::addr_t    base_addr_i,
   input  wire page_ctrl_pkg::page_cnt_t page_limit_i,
   // completion from the engines
   input  wire                          wr_page_done_i,
   input  wire                          rd_page_done_i,
   // engine starts and slot addresses
   output logic                         wr_start_o,
   output axi_burst_pkg::addr_t         wr_addr_o,
   output logic                         rd_start_o,
   output axi_burst_pkg::addr_t         rd_addr_o,
   // status
   output page_ctrl_pkg::page_cnt_t     pages_written_o,
   output page_ctrl_pkg::page_cnt_t     pages_read_o,
   output logic                         mem_full_o
);

   logic                     wr_busy;
   logic                     rd_busy;
   logic                     wr_accept;
   logic                     rd_accept;
   page_ctrl_pkg::page_cnt_t wr_cnt_nxt;
   page_ctrl_pkg::page_cnt_t rd_cnt_nxt;

   ////////////////////////////////////////
   // command gating
   ////////////////////////////////////////

   assign wr_accept  = write_page_i && !wr_busy && !mem_full_o;
   // only pages whose write has completed can be read
   assign rd_accept  = read_page_i && !rd_busy && (pages_read_o < pages_written_o);
   assign wr_cnt_nxt = pages_written_o + 1'b1;
   assign rd_cnt_nxt = pages_read_o + 1'b1;

   // slot = base + count * page bytes
   always_ff @(posedge sysclk_i)
   begin
      if (wr_accept)
      begin
         wr_addr_o <= base_addr_i + axi_burst_pkg::addr_t'(pages_written_o)
                      * axi_burst_pkg::addr_t'(`DPF_PAGE_BYTES);
      end
      if (rd_accept)
      begin
         rd_addr_o <= base_addr_i + axi_burst_pkg::addr_t'(pages_read_o)
                      * axi_burst_pkg::addr_t'(`DPF_PAGE_BYTES);
      end
   end

   ////////////////////////////////////////
   // counts, busy and full flags
   ////////////////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         wr_start_o      <= 1'b0;
         rd_start_o      <= 1'b0;
         wr_busy         <= 1'b0;
         rd_busy         <= 1'b0;
         pages_written_o <= '0;
         pages_read_o    <= '0;
         mem_full_o      <= 1'b0;
      end
      else
      begin
         wr_start_o <= wr_accept;
         rd_start_o <= rd_accept;
         // busy from accept until the engine reports done
         if (wr_accept)
         begin
            wr_busy <= 1'b1;
         end
         else if (wr_page_done_i)
         begin
            wr_busy <= 1'b0;
         end
         if (rd_accept)
         begin
            rd_busy <= 1'b1;
         end
         else if (rd_page_done_i)
         begin
            rd_busy <= 1'b0;
         end
         // no write can complete while full, so the clear never races a write
         if (wr_page_done_i)
         begin
            pages_written_o <= wr_cnt_nxt;
            if (wr_cnt_nxt == page_limit_i)
            begin
               mem_full_o <= 1'b1;
            end
         end
         if (rd_page_done_i)
         begin
            // last held page read out, region is empty again
            if (mem_full_o && (rd_cnt_nxt == pages_written_o))
            begin
               pages_written_o <= '0;
               pages_read_o    <= '0;
               mem_full_o      <= 1'b0;
            end
            else
            begin
               pages_read_o <= rd_cnt_nxt;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/page_read_engine.sv ====
// reads one page per start pulse as a single INCR read burst
// output FIFO must take every beat, there is no back-pressure path
`default_nettype none

`include "ddr_page_fifo_macros.svh"

module page_read_engine
(
   input  wire                        sysclk_i,
   input  wire                        reset,
   // command from the ledger
   input  wire                        start_i,
   input  wire axi_burst_pkg::addr_t  page_addr_i,
   // AXI read address channel
   output axi_burst_pkg::addr_t       araddr_o,
   output axi_burst_pkg::beat_cnt_t   arlen_o,
   output logic                       arvalid_o,
   input  wire                        arready_i,
   // AXI read data channel
   input  wire axi_burst_pkg::beat_t  rdata_i,
   input  wire                        rlast_i,
   input  wire                        rvalid_i,
   output logic                       rready_o,
   // output FIFO
   output axi_burst_pkg::beat_t       out_data_o,
   output logic                       out_we_o,
   // page finished, back to the ledger
   output logic                       page_done_o
);

   page_ctrl_pkg::rd_state_t   state;
   logic                       beat_xfer;

   // one burst covers the whole page
   assign arlen_o   = axi_burst_pkg::beat_cnt_t'(`DPF_BEATS_PER_PAGE - 1);

   // ready for data only after the address handshake
   assign rready_o  = (state == page_ctrl_pkg::RD_DATA);
   assign beat_xfer = rready_o && rvalid_i;

   ////////////////////////////////////////
   // payload registers
   ////////////////////////////////////////

   always_ff @(posedge sysclk_i)
   begin
      if ((state == page_ctrl_pkg::RD_IDLE) && start_i)
      begin
         araddr_o <= page_addr_i;
      end
      // each beat lands in the output register one cycle later
      if (beat_xfer)
      begin
         out_data_o <= rdata_i;
      end
   end

   ////////////////////////////////////////
   // read FSM
   ////////////////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         state       <= page_ctrl_pkg::RD_IDLE;
         arvalid_o   <= 1'b0;
         out_we_o    <= 1'b0;
         page_done_o <= 1'b0;
      end
      else
      begin
         // write strobe follows the beat handshake by one cycle
         out_we_o    <= beat_xfer;
         page_done_o <= 1'b0;
         case (state)
            page_ctrl_pkg::RD_IDLE:
            begin
               if (start_i)
               begin
                  arvalid_o <= 1'b1;
                  state     <= page_ctrl_pkg::RD_ADDR;
               end
            end
            // hold arvalid and the address until accepted
            page_ctrl_pkg::RD_ADDR:
            begin
               if (arready_i)
               begin
                  arvalid_o <= 1'b0;
                  state     <= page_ctrl_pkg::RD_DATA;
               end
            end
            // rlast ends the page, done lines up with the last write strobe
            page_ctrl_pkg::RD_DATA:
            begin
               if (beat_xfer && rlast_i)
               begin
                  page_done_o <= 1'b1;
                  state       <= page_ctrl_pkg::RD_IDLE;
               end
            end
            default:
            begin
               state <= page_ctrl_pkg::RD_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/page_write_engine.sv ====
// moves one page per start pulse as a single INCR write burst
// input FIFO must be first-word-fall-through; bresp is not checked
`default_nettype none

`include "ddr_page_fifo_macros.svh"

module page_write_engine
(
   input  wire                        sysclk_i,
   input  wire                        reset,
   // command from the ledger
   input  wire                        start_i,
   input  wire axi_burst_pkg::addr_t  page_addr_i,
   // input FIFO
   input  wire axi_burst_pkg::beat_t  in_data_i,
   input  wire                        in_empty_i,
   output logic                       in_rd_o,
   // AXI write address channel
   output axi_burst_pkg::addr_t       awaddr_o,
   output axi_burst_pkg::beat_cnt_t   awlen_o,
   output logic                       awvalid_o,
   input  wire                        awready_i,
   // AXI write data channel
   output axi_burst_pkg::beat_t       wdata_o,
   output logic                       wlast_o,
   output logic                       wvalid_o,
   input  wire                        wready_i,
   // AXI write response channel
   input  wire                        bvalid_i,
   output logic                       bready_o,
   // page finished, back to the ledger
   output logic                       page_done_o
);

   // awlen encoding of one page
   localparam axi_burst_pkg::beat_cnt_t LAST_BEAT =
      axi_burst_pkg::beat_cnt_t'(`DPF_BEATS_PER_PAGE - 1);

   page_ctrl_pkg::wr_state_t   state;
   axi_burst_pkg::beat_cnt_t   beat_cnt;
   logic                       beat_xfer;

   ////////////////////////////////////////
   // data path straight from the FIFO
   ////////////////////////////////////////

   assign awlen_o = LAST_BEAT;

   // FIFO head only leaves on a pop, so wvalid cannot drop before wready
   assign wvalid_o  = (state == page_ctrl_pkg::WR_DATA) && !in_empty_i;
   assign wdata_o   = in_data_i;
   assign wlast_o   = (state == page_ctrl_pkg::WR_DATA) && (beat_cnt == LAST_BEAT);
   assign beat_xfer = wvalid_o && wready_i;
   // pop exactly the beat the slave took
   assign in_rd_o   = beat_xfer;

   assign bready_o  = (state == page_ctrl_pkg::WR_RESP);

   // slot address is latched once per page
   always_ff @(posedge sysclk_i)
   begin
      if ((state == page_ctrl_pkg::WR_IDLE) && start_i)
      begin
         awaddr_o <= page_addr_i;
      end
   end

   ////////////////////////////////////////
   // write FSM
   ////////////////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         state       <= page_ctrl_pkg::WR_IDLE;
         awvalid_o   <= 1'b0;
         beat_cnt    <= '0;
         page_done_o <= 1'b0;
      end
      else
      begin
         // done is a single cycle pulse
         page_done_o <= 1'b0;
         case (state)
            page_ctrl_pkg::WR_IDLE:
            begin
               beat_cnt <= '0;
               if (start_i)
               begin
                  awvalid_o <= 1'b1;
                  state     <= page_ctrl_pkg::WR_ADDR;
               end
            end
            // hold awvalid and the address until accepted
            page_ctrl_pkg::WR_ADDR:
            begin
               if (awready_i)
               begin
                  awvalid_o <= 1'b0;
                  state     <= page_ctrl_pkg::WR_DATA;
               end
            end
            page_ctrl_pkg::WR_DATA:
            begin
               if (beat_xfer)
               begin
                  beat_cnt <= beat_cnt + 1'b1;
                  // last beat went out
                  if (beat_cnt == LAST_BEAT)
                  begin
                     state <= page_ctrl_pkg::WR_RESP;
                  end
               end
            end
            page_ctrl_pkg::WR_RESP:
            begin
               if (bvalid_i)
               begin
                  page_done_o <= 1'b1;
                  state       <= page_ctrl_pkg::WR_IDLE;
               end
            end
            default:
            begin
               state <= page_ctrl_pkg::WR_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire
